// ==== compile.f ====
hw/pwm_pkg.sv
hw/pwm_regs.sv
hw/pwm_strobe_gen.sv
hw/pwm_channel.sv
hw/pwm_periph.sv
testbench/pwm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PWM testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module pwm_tb -o pwm_sim

out=$(./obj_dir/pwm_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// ==== testbench/pwm_tb.sv ====
// Self-checking testbench for the two-channel PWM peripheral.
// Stimulus rows keep the period within 1 to 3 so every frame stays short.
// Duty is measured on uo_out[7] and uo_out[6] over one full frame per row.
// Period 0 (divide by 256) is not exercised.

`timescale 1ns/10ps

module pwm_tb import pwm_pkg::*; ();

    localparam int n_rows       = 7;    // Five fixed rows and two random rows.
    localparam int n_fixed      = 5;
    localparam int frame_len    = 256;  // Strobes per PWM frame.
    localparam int settle_slack = 8;    // Extra clocks after the shadow level loads.

    logic              clk;
    logic              rst_n;
    logic [addr_w-1:0] address;
    logic              data_write;
    logic [pwm_w-1:0]  data_in;
    logic [pwm_w-1:0]  data_out;
    logic [7:0]        uo_out;

    pwm_cfg_t rows [n_rows];   // Stimulus table, one configuration per row.
    int       high0 [n_rows];  // Measured high clocks of channel 0.
    int       high1 [n_rows];  // Measured high clocks of channel 1.

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;  // Zero until the table is known.
    logic [31:0] rng_state;

    pwm_periph dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data_write (data_write),
        .data_in    (data_in),
        .data_out   (data_out),
        .uo_out     (uo_out)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;  // 8 ns period.

    // Watchdog on the total cycle budget.
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // 32-bit xorshift generator.
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int max_int(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // Cycle budget: register tests, then a settle frame and a measure frame per row.
    function automatic int compute_limit();
        int total;
        int prev;
        int per;
        total = 200 + 16 + frame_len + 64;  // Slack, reset, reset frame, register tests.
        prev  = 1;
        for (int i = 0; i < n_rows; i++) begin
            per   = int'(rows[i].period);
            total = total + 2 * frame_len * max_int(prev, per) + 32;
            prev  = per;
        end
        return total;
    endfunction

    task automatic fill_table();
        rows[0] = '{level0: 8'd0,   level1: 8'd255, period: 8'd1};
        rows[1] = '{level0: 8'd255, level1: 8'd0,   period: 8'd2};
        rows[2] = '{level0: 8'd128, level1: 8'd1,   period: 8'd3};
        rows[3] = '{level0: 8'd1,   level1: 8'd128, period: 8'd1};
        rows[4] = '{level0: 8'd128, level1: 8'd255, period: 8'd2};
        for (int i = n_fixed; i < n_rows; i++) begin
            rng_state      = xorshift32(rng_state);
            rows[i].level0 = rng_state[7:0];
            rows[i].level1 = rng_state[15:8];
            rows[i].period = 8'(1 + (rng_state[23:16] % 3));  // Keeps the period in 1..3.
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        check_count = check_count + 1;
        if (actual != expected) begin
            error_count = error_count + 1;
            $display("CHECK FAILED at %0t: %s expected 'h%0h, got 'h%0h",
                     $time, name, expected, actual);
        end
    endtask

    // One-cycle write, driven on the falling edge.
    task automatic write_reg(input logic [addr_w-1:0] a, input logic [pwm_w-1:0] d);
        @(negedge clk);
        address    = a;
        data_in    = d;
        data_write = 1'b1;
        @(negedge clk);
        data_write = 1'b0;
    endtask

    // Read-back sampled on the rising edge, a half cycle after the address settles.
    task automatic read_check(input logic [addr_w-1:0] a, input int expected);
        @(negedge clk);
        address    = a;
        data_write = 1'b0;
        @(posedge clk);
        check_value($sformatf("data_out[addr %0d]", a), expected, int'(data_out));
    endtask

    // Counts high clocks of both channels over one frame, checking the pin map each cycle.
    task automatic measure_frame(input int period, output int count0, output int count1);
        logic ref_pin;
        count0 = 0;
        count1 = 0;
        repeat (frame_len * period) begin
            @(posedge clk);
            for (int b = 0; b < 6; b++) begin
                // Odd pins follow pin 7 and even pins follow pin 6.
                ref_pin = (b % 2 == 1) ? uo_out[7] : uo_out[6];
                check_value($sformatf("uo_out[%0d]", b), int'(ref_pin), int'(uo_out[b]));
            end
            if (uo_out[7]) count0 = count0 + 1;
            if (uo_out[6]) count1 = count1 + 1;
        end
    endtask

    initial begin
        int prev_period;
        int period;
        int hold;
        int c0;
        int c1;

        rst_n      = 1'b0;
        address    = '0;
        data_write = 1'b0;
        data_in    = '0;
        rng_state  = 32'hae601351;
        fill_table();
        cycle_limit = compute_limit();

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values, then a quiet frame on every pin.
        read_check(reg_level0, 0);
        read_check(reg_level1, 0);
        read_check(reg_period, 1);
        measure_frame(1, c0, c1);
        check_value("uo_out[7] high clocks after reset", 0, c0);
        check_value("uo_out[6] high clocks after reset", 0, c1);

        // Holes in the map read zero and ignore writes.
        for (int a = 3; a < 16; a++) begin
            write_reg(4'(a), 8'(8'ha5 ^ a));
            read_check(4'(a), 0);
        end
        read_check(reg_level0, 0);
        read_check(reg_level1, 0);
        read_check(reg_period, 1);

        prev_period = 1;
        for (int i = 0; i < n_rows; i++) begin
            period = int'(rows[i].period);
            write_reg(reg_level0, rows[i].level0);
            write_reg(reg_level1, rows[i].level1);
            write_reg(reg_period, rows[i].period);
            read_check(reg_level0, int'(rows[i].level0));
            read_check(reg_level1, int'(rows[i].level1));
            read_check(reg_period, period);

            // Next frame wrap may still run at the old period.
            hold = frame_len * max_int(prev_period, period) + settle_slack;
            repeat (hold) @(posedge clk);

            measure_frame(period, high0[i], high1[i]);
            check_value($sformatf("row %0d uo_out[7] high clocks", i),
                        int'(rows[i].level0) * period, high0[i]);
            check_value($sformatf("row %0d uo_out[6] high clocks", i),
                        int'(rows[i].level1) * period, high1[i]);
            prev_period = period;
        end

        // Same level at another period scales the high time by the period ratio.
        for (int i = 0; i < n_rows; i++) begin
            for (int j = i + 1; j < n_rows; j++) begin
                if (rows[i].period != rows[j].period) begin
                    if (rows[i].level0 == rows[j].level0) begin
                        check_value($sformatf("uo_out[7] scaling rows %0d/%0d", i, j),
                                    high0[i] * int'(rows[j].period),
                                    high0[j] * int'(rows[i].period));
                    end
                    if (rows[i].level1 == rows[j].level1) begin
                        check_value($sformatf("uo_out[6] scaling rows %0d/%0d", i, j),
                                    high1[i] * int'(rows[j].period),
                                    high1[j] * int'(rows[i].period));
                    end
                end
            end
        end

        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/pwm_periph.sv ====
// Two-channel PWM peripheral for the SoC byte bus.
// Registers: 0 level0, 1 level1, 2 strobe period; all other addresses read zero.
// Channel 0 drives the odd output pins and channel 1 the even ones.

`timescale 1ns/10ps

module pwm_periph import pwm_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] address,     // Register select.
    input  logic              data_write,  // One-cycle write strobe.
    input  logic [pwm_w-1:0]  data_in,     // Write data.
    output logic [pwm_w-1:0]  data_out,    // Combinational read data.
    output logic [7:0]        uo_out       // Output pins.
);

    pwm_cfg_t cfg;        // Register contents.
    logic     strobe;     // Shared phase advance.
    logic     chan0_out;
    logic     chan1_out;

    pwm_regs regs_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .address    (address),
        .data_write (data_write),
        .data_in    (data_in),
        .data_out   (data_out),
        .cfg        (cfg)
    );

    // One divider feeds both channels so their frames stay aligned.
    pwm_strobe_gen strobe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .period (cfg.period),
        .strobe (strobe)
    );

    pwm_channel chan0_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .strobe (strobe),
        .level  (cfg.level0),
        .out    (chan0_out)
    );

    pwm_channel chan1_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .strobe (strobe),
        .level  (cfg.level1),
        .out    (chan1_out)
    );

    // Bits 7,5,3,1 carry channel 0 and bits 6,4,2,0 carry channel 1.
    assign uo_out = {4{chan0_out, chan1_out}};

endmodule

// ==== hw/pwm_channel.sv ====
// Single PWM channel driven by the shared strobe.
// One frame is 256 strobes; out is high for the first level strobes of each frame.
// The level is sampled into a shadow copy at frame wrap, so edits never cut a frame short.
// out is registered and lags the phase by one clock.

`timescale 1ns/10ps

module pwm_channel import pwm_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             strobe,  // Phase advance pulse.
    input  logic [pwm_w-1:0] level,   // Live duty level from the registers.
    output logic             out      // PWM output.
);

    logic [pwm_w-1:0] phase;       // Position inside the frame.
    logic [pwm_w-1:0] shadow;      // Level used for the current frame.
    logic             phase_last;  // Last strobe slot of the frame.

    assign phase_last = (phase == '1);

    // Phase counter and shadow reload.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase  <= '0;
            shadow <= '0;
        end else if (strobe) begin
            phase <= phase + pwm_w'(1);  // Wraps 255 -> 0.
            if (phase_last) begin
                shadow <= level;         // New frame, new level.
            end
        end
    end

    // Registered compare keeps the pin free of decode glitches.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out <= 1'b0;
        end else begin
            out <= (phase < shadow);
        end
    end

    // The shadow only moves at phase 255, where the compare is already false,
    // so a zero level must never leave a stray high cycle on the pin.
    a_zero_level_low: assert property (
        @(posedge clk) disable iff (!rst_n)
        (shadow == '0) |-> !out
    );

endmodule

// ==== hw/pwm_strobe_gen.sv ====
// Clock divider that issues a one-cycle strobe every period clocks.
// A period of 0 counts the full 256 clocks.
// A new period is taken in only when the current count wraps, so a running count finishes.

`timescale 1ns/10ps

module pwm_strobe_gen import pwm_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [pwm_w-1:0] period,  // Requested clocks per strobe.
    output logic             strobe   // One-cycle pulse.
);

    logic [pwm_w-1:0] cnt;       // Divider count, 0 to period-1.
    logic [pwm_w-1:0] period_q;  // Period in use for the running count.
    logic [pwm_w-1:0] last_cnt;  // Terminal count, wraps to 255 when period is 0.
    logic             match;

    assign last_cnt = period_q - pwm_w'(1);
    assign match    = (cnt == last_cnt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= '0;
            period_q <= period_reset;
            strobe   <= 1'b0;
        end else if (match) begin
            cnt      <= '0;       // Wrap and pick up any new period.
            period_q <= period;
            strobe   <= 1'b1;
        end else begin
            cnt    <= cnt + pwm_w'(1);
            strobe <= 1'b0;
        end
    end

    // Back-to-back strobes only happen when the running period was 1.
    a_strobe_spacing: assert property (
        @(posedge clk) disable iff (!rst_n)
        strobe |=> (!strobe || ($past(period_q) == pwm_w'(1)))
    );

endmodule

// ==== hw/pwm_regs.sv ====
// Host register block for the two-channel PWM.
// Writes take effect on the edge where data_write is high, no other handshake exists.
// Read-back is combinational on address; unmapped addresses read zero and ignore writes.

`timescale 1ns/10ps

module pwm_regs import pwm_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [addr_w-1:0] address,     // Register select from the host.
    input  logic              data_write,  // One-cycle write strobe.
    input  logic [pwm_w-1:0]  data_in,     // Write data, valid with data_write.
    output logic [pwm_w-1:0]  data_out,    // Read data for the current address.
    output pwm_cfg_t          cfg          // Live register contents.
);

    reg_addr_e reg_sel;      // Address viewed through the register map.
    logic      addr_mapped;  // High when address hits a real register.

    assign reg_sel     = reg_addr_e'(address);
    assign addr_mapped = (address <= reg_period);

    // Write decode.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.level0 <= '0;            // Both channels start fully low.
            cfg.level1 <= '0;
            cfg.period <= period_reset;  // Strobe every clock.
        end else if (data_write) begin
            case (reg_sel)
                reg_level0: cfg.level0 <= data_in;
                reg_level1: cfg.level1 <= data_in;
                reg_period: cfg.period <= data_in;
                default: begin
                    // Unmapped address, nothing is stored.
                end
            endcase
        end
    end

    // Read-back mux.
    always_comb begin
        case (reg_sel)
            reg_level0: data_out = cfg.level0;
            reg_level1: data_out = cfg.level1;
            reg_period: data_out = cfg.period;
            default:    data_out = '0;  // Holes in the map read as zero.
        endcase
    end

    // Any address outside the register map must read back zero.
    a_unmapped_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        !addr_mapped |-> (data_out == '0)
    );

endmodule

// ==== hw/pwm_pkg.sv ====
// Shared widths, register map and the configuration struct of the PWM peripheral.
// All datapath widths follow pwm_w, so level, phase and period must stay equal in width.
// Register addresses fill the low part of the addr_w space and the rest stays unmapped.

package pwm_pkg;

    // Datapath width for level, phase and strobe period.
    localparam int pwm_w = 8;

    // Width of the host bus address.
    localparam int addr_w = 4;

    // Register map seen by the host.
    typedef enum logic [addr_w-1:0] {
        reg_level0 = 4'd0,  // Channel 0 duty level.
        reg_level1 = 4'd1,  // Channel 1 duty level.
        reg_period = 4'd2   // Strobe period in clocks, 0 means 256.
    } reg_addr_e;

    // Divider runs at full rate out of reset.
    localparam logic [pwm_w-1:0] period_reset = 8'd1;

    // Register contents handed to the rest of the pipeline.
    // Field order sets the packed layout, level0 sits in the top byte.
    typedef struct packed {
        logic [pwm_w-1:0] level0;  // Channel 0 duty level.
        logic [pwm_w-1:0] level1;  // Channel 1 duty level.
        logic [pwm_w-1:0] period;  // Clocks per strobe.
    } pwm_cfg_t;

endpackage
